/* cpu_pkg.sv */
package cpu_pkg;

    localparam int DATA_W   = 16;
    localparam int REG_AW   = 3;
    localparam int NUM_REGS = 8;

    typedef logic [DATA_W-1:0] word_t;
    typedef logic [DATA_W-1:0] inst_t;
    typedef logic [DATA_W-1:0] pc_t;
    typedef logic [REG_AW-1:0] reg_addr_t;

    // instruction fields
    localparam int OPCODE_HI = 15;
    localparam int OPCODE_LO = 11;
    localparam int RX_HI     = 10;
    localparam int RY_HI     = 7;
    localparam int RZ_HI     = 4;

    // major opcodes
    localparam logic [4:0] OP_LI    = 5'b01101;
    localparam logic [4:0] OP_ADDIU = 5'b01001;
    localparam logic [4:0] OP_RRR   = 5'b11100;
    localparam logic [4:0] OP_LW    = 5'b10011;
    localparam logic [4:0] OP_SW    = 5'b11011;
    localparam logic [4:0] OP_BEQZ  = 5'b00100;
    localparam logic [4:0] OP_B     = 5'b00010;
    localparam logic [4:0] OP_NOP   = 5'b00001;

    // rrr function field in bits 1:0
    localparam logic [1:0] FUNCT_ADDU = 2'b01;
    localparam logic [1:0] FUNCT_SUBU = 2'b11;

    typedef enum logic [1:0] {
        ALU_ADD    = 2'd0,
        ALU_SUB    = 2'd1,
        ALU_PASS_B = 2'd2
    } alu_op_e;

    typedef enum logic {
        WB_ALU = 1'b0,
        WB_MEM = 1'b1
    } wb_src_e;

    typedef enum logic [1:0] {
        BR_NONE   = 2'd0,
        BR_ZERO   = 2'd1,
        BR_ALWAYS = 2'd2
    } branch_e;

    // ****************************************
    // stage payloads where all zero is a bubble
    // ****************************************

    typedef struct packed {
        inst_t inst;
        pc_t   pc_plus1;
    } if_id_t;

    typedef struct packed {
        pc_t       pc_plus1;
        word_t     rd_a;
        word_t     rd_b;
        reg_addr_t src_a;
        reg_addr_t src_b;
        reg_addr_t dest;
        word_t     imm;
        alu_op_e   alu_op;
        logic      use_imm;
        logic      reg_write;
        wb_src_e   wb_src;
        logic      mem_read;
        logic      mem_write;
        branch_e   branch;
    } id_ex_t;

    typedef struct packed {
        word_t     result;
        word_t     store_data;
        reg_addr_t dest;
        logic      reg_write;
        wb_src_e   wb_src;
        logic      mem_read;
        logic      mem_write;
    } ex_mem_t;

    typedef struct packed {
        word_t     result;
        word_t     load_data;
        reg_addr_t dest;
        logic      reg_write;
        wb_src_e   wb_src;
    } mem_wb_t;

endpackage

/* fetch_unit.sv */
`timescale 1ns/100ps

module fetch_unit import cpu_pkg::*; (
    input  logic clk_50MHz,
    input  logic rst,
    input  logic stall_i,
    input  logic take_branch_i,
    input  pc_t  branch_target_i,
    output pc_t  pc_o,
    output pc_t  pc_plus1_o
);

    pc_t pc_q;
    pc_t pc_next;

    assign pc_plus1_o = pc_q + pc_t'(1);
    assign pc_o       = pc_q;

    // redirect wins over a load-use hold
    always_comb begin
        if (take_branch_i)
            pc_next = branch_target_i;
        else if (stall_i)
            pc_next = pc_q;
        else
            pc_next = pc_plus1_o;
    end

    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst)
            pc_q <= '0;
        else
            pc_q <= pc_next;
    end

endmodule

/* pipe_reg.sv */
`timescale 1ns/100ps

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk_50MHz,
    input  logic     rst,
    input  logic     hold_i,
    input  logic     clear_i,
    input  payload_t data_i,
    output payload_t data_o
);

    // clear has priority over hold
    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            data_o <= '0;
        end else if (clear_i) begin
            data_o <= '0;
        end else if (!hold_i) begin
            data_o <= data_i;
        end
    end

endmodule

/* decoder.sv */
`timescale 1ns/100ps

module decoder import cpu_pkg::*; (
    input  inst_t     inst_i,
    output reg_addr_t src_a_o,
    output reg_addr_t src_b_o,
    output reg_addr_t dest_o,
    output logic      uses_a_o,
    output logic      uses_b_o,
    output word_t     imm_o,
    output alu_op_e   alu_op_o,
    output logic      use_imm_o,
    output logic      reg_write_o,
    output wb_src_e   wb_src_o,
    output logic      mem_read_o,
    output logic      mem_write_o,
    output branch_e   branch_o
);

    logic [4:0] opcode;
    logic [1:0] funct;
    reg_addr_t  rx, ry, rz;
    word_t      imm_z8, imm_s8, imm_s5, imm_s11;

    assign opcode = inst_i[OPCODE_HI:OPCODE_LO];
    assign funct  = inst_i[1:0];
    assign rx     = inst_i[RX_HI -: REG_AW];
    assign ry     = inst_i[RY_HI -: REG_AW];
    assign rz     = inst_i[RZ_HI -: REG_AW];

    // immediate forms
    assign imm_z8  = {8'b0, inst_i[7:0]};
    assign imm_s8  = {{8{inst_i[7]}}, inst_i[7:0]};
    assign imm_s5  = {{11{inst_i[4]}}, inst_i[4:0]};
    assign imm_s11 = {{5{inst_i[10]}}, inst_i[10:0]};

    always_comb begin
        src_a_o     = rx;
        src_b_o     = ry;
        dest_o      = rx;
        uses_a_o    = 1'b0;
        uses_b_o    = 1'b0;
        imm_o       = '0;
        alu_op_o    = ALU_ADD;
        use_imm_o   = 1'b0;
        reg_write_o = 1'b0;
        wb_src_o    = WB_ALU;
        mem_read_o  = 1'b0;
        mem_write_o = 1'b0;
        branch_o    = BR_NONE;
        case (opcode)
            OP_LI: begin
                imm_o       = imm_z8;
                use_imm_o   = 1'b1;
                alu_op_o    = ALU_PASS_B;
                reg_write_o = 1'b1;
            end
            OP_ADDIU: begin
                uses_a_o    = 1'b1;
                imm_o       = imm_s8;
                use_imm_o   = 1'b1;
                reg_write_o = 1'b1;
            end
            OP_RRR: begin
                if (funct == FUNCT_ADDU || funct == FUNCT_SUBU) begin
                    uses_a_o    = 1'b1;
                    uses_b_o    = 1'b1;
                    dest_o      = rz;
                    alu_op_o    = (funct == FUNCT_SUBU) ? ALU_SUB : ALU_ADD;
                    reg_write_o = 1'b1;
                end
            end
            OP_LW: begin
                uses_a_o    = 1'b1;
                dest_o      = ry;
                imm_o       = imm_s5;
                use_imm_o   = 1'b1;
                reg_write_o = 1'b1;
                wb_src_o    = WB_MEM;
                mem_read_o  = 1'b1;
            end
            OP_SW: begin
                // rx is the base, ry the store data
                uses_a_o    = 1'b1;
                uses_b_o    = 1'b1;
                imm_o       = imm_s5;
                use_imm_o   = 1'b1;
                mem_write_o = 1'b1;
            end
            OP_BEQZ: begin
                uses_a_o = 1'b1;
                imm_o    = imm_s8;
                branch_o = BR_ZERO;
            end
            OP_B: begin
                imm_o    = imm_s11;
                branch_o = BR_ALWAYS;
            end
            OP_NOP: begin
            end
            // unknown opcodes behave as nop
            default: begin
            end
        endcase
    end

endmodule

/* reg_file.sv */
`timescale 1ns/100ps

module reg_file import cpu_pkg::*; (
    input  logic      clk_50MHz,
    input  logic      rst,
    input  reg_addr_t rd_a_i,
    input  reg_addr_t rd_b_i,
    input  reg_addr_t wr_addr_i,
    input  logic      wr_en_i,
    input  wb_src_e   wb_src_i,
    input  word_t     alu_data_i,
    input  word_t     mem_data_i,
    output word_t     rd_a_data_o,
    output word_t     rd_b_data_o,
    output word_t     wb_data_o
);

    word_t regs [NUM_REGS];

    // write-back source select
    assign wb_data_o = (wb_src_i == WB_MEM) ? mem_data_i : alu_data_i;

    // same-cycle write is visible to the reader
    assign rd_a_data_o = (wr_en_i && wr_addr_i == rd_a_i) ? wb_data_o : regs[rd_a_i];
    assign rd_b_data_o = (wr_en_i && wr_addr_i == rd_b_i) ? wb_data_o : regs[rd_b_i];

    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i) begin
            regs[wr_addr_i] <= wb_data_o;
        end
    end

endmodule

/* hazard_unit.sv */
`timescale 1ns/100ps

module hazard_unit import cpu_pkg::*; (
    input  reg_addr_t src_a_i,
    input  reg_addr_t src_b_i,
    input  logic      uses_a_i,
    input  logic      uses_b_i,
    input  logic      ex_mem_read_i,
    input  reg_addr_t ex_dest_i,
    input  logic      take_branch_i,
    output logic      stall_o,
    output logic      bubble_o,
    output logic      flush_o
);

    logic load_use;

    // load in EX feeding the instruction in ID
    assign load_use = ex_mem_read_i &&
                      ((uses_a_i && src_a_i == ex_dest_i) ||
                       (uses_b_i && src_b_i == ex_dest_i));

    // a taken branch kills ID anyway, so no stall then
    assign flush_o  = take_branch_i;
    assign stall_o  = load_use && !take_branch_i;
    assign bubble_o = stall_o;

endmodule

/* execute_unit.sv */
`timescale 1ns/100ps

module execute_unit import cpu_pkg::*; (
    input  id_ex_t    id_ex_i,
    input  reg_addr_t mem_dest_i,
    input  logic      mem_reg_write_i,
    input  logic      mem_is_load_i,
    input  word_t     mem_result_i,
    input  reg_addr_t wb_dest_i,
    input  logic      wb_reg_write_i,
    input  word_t     wb_data_i,
    output word_t     result_o,
    output word_t     store_data_o,
    output logic      take_branch_o,
    output pc_t       branch_target_o
);

    word_t op_a;
    word_t op_b;
    word_t alu_b;

    // youngest producer first, loads in MEM are covered by the stall
    function automatic word_t forward(input reg_addr_t src, input word_t reg_val);
        word_t val;
        if (mem_reg_write_i && !mem_is_load_i && mem_dest_i == src)
            val = mem_result_i;
        else if (wb_reg_write_i && wb_dest_i == src)
            val = wb_data_i;
        else
            val = reg_val;
        return val;
    endfunction

    always_comb begin
        op_a = forward(id_ex_i.src_a, id_ex_i.rd_a);
        op_b = forward(id_ex_i.src_b, id_ex_i.rd_b);
    end

    assign alu_b        = id_ex_i.use_imm ? id_ex_i.imm : op_b;
    assign store_data_o = op_b;

    // ****************************************
    // alu
    // ****************************************
    always_comb begin
        case (id_ex_i.alu_op)
            ALU_ADD:    result_o = op_a + alu_b;
            ALU_SUB:    result_o = op_a - alu_b;
            ALU_PASS_B: result_o = alu_b;
            default:    result_o = op_a + alu_b;
        endcase
    end

    // branch resolution
    always_comb begin
        case (id_ex_i.branch)
            BR_ZERO:   take_branch_o = (op_a == '0);
            BR_ALWAYS: take_branch_o = 1'b1;
            default:   take_branch_o = 1'b0;
        endcase
    end

    assign branch_target_o = id_ex_i.pc_plus1 + id_ex_i.imm;

endmodule

/* cpu_top.sv */
`timescale 1ns/100ps

module cpu_top import cpu_pkg::*; (
    input  logic  clk_50MHz,
    input  logic  rst,
    input  inst_t imem_data_i,
    output pc_t   imem_addr_o,
    input  word_t dmem_rdata_i,
    output logic  dmem_en_o,
    output logic  dmem_we_o,
    output word_t dmem_addr_o,
    output word_t dmem_wdata_o
);

    if_id_t  if_id_d, if_id_q;
    id_ex_t  id_ex_d, id_ex_q;
    ex_mem_t ex_mem_d, ex_mem_q;
    mem_wb_t mem_wb_d, mem_wb_q;

    logic stall, bubble, flush;
    logic take_branch;
    pc_t  branch_target;
    pc_t  pc_plus1;

    reg_addr_t src_a, src_b, dest;
    logic      uses_a, uses_b;
    word_t     imm;
    alu_op_e   alu_op;
    logic      use_imm, reg_write, mem_read, mem_write;
    wb_src_e   wb_src;
    branch_e   branch;
    word_t     rd_a_data, rd_b_data, wb_data;
    word_t     ex_result, ex_store_data;

    // ****************************************
    // IF
    // ****************************************
    fetch_unit fetch_unit_i (
        .clk_50MHz(clk_50MHz), .rst(rst),
        .stall_i(stall), .take_branch_i(take_branch), .branch_target_i(branch_target),
        .pc_o(imem_addr_o), .pc_plus1_o(pc_plus1)
    );

    assign if_id_d = '{inst: imem_data_i, pc_plus1: pc_plus1};

    pipe_reg #(.payload_t(if_id_t)) if_id_reg_i (
        .clk_50MHz(clk_50MHz), .rst(rst), .hold_i(stall), .clear_i(flush),
        .data_i(if_id_d), .data_o(if_id_q)
    );

    // ****************************************
    // ID
    // ****************************************
    decoder decoder_i (
        .inst_i(if_id_q.inst),
        .src_a_o(src_a), .src_b_o(src_b), .dest_o(dest),
        .uses_a_o(uses_a), .uses_b_o(uses_b), .imm_o(imm),
        .alu_op_o(alu_op), .use_imm_o(use_imm), .reg_write_o(reg_write),
        .wb_src_o(wb_src), .mem_read_o(mem_read), .mem_write_o(mem_write),
        .branch_o(branch)
    );

    reg_file reg_file_i (
        .clk_50MHz(clk_50MHz), .rst(rst),
        .rd_a_i(src_a), .rd_b_i(src_b), .wr_addr_i(mem_wb_q.dest),
        .wr_en_i(mem_wb_q.reg_write), .wb_src_i(mem_wb_q.wb_src),
        .alu_data_i(mem_wb_q.result), .mem_data_i(mem_wb_q.load_data),
        .rd_a_data_o(rd_a_data), .rd_b_data_o(rd_b_data), .wb_data_o(wb_data)
    );

    hazard_unit hazard_unit_i (
        .src_a_i(src_a), .src_b_i(src_b), .uses_a_i(uses_a), .uses_b_i(uses_b),
        .ex_mem_read_i(id_ex_q.mem_read), .ex_dest_i(id_ex_q.dest),
        .take_branch_i(take_branch),
        .stall_o(stall), .bubble_o(bubble), .flush_o(flush)
    );

    assign id_ex_d = '{pc_plus1: if_id_q.pc_plus1, rd_a: rd_a_data, rd_b: rd_b_data,
                       src_a: src_a, src_b: src_b, dest: dest, imm: imm,
                       alu_op: alu_op, use_imm: use_imm, reg_write: reg_write,
                       wb_src: wb_src, mem_read: mem_read, mem_write: mem_write,
                       branch: branch};

    pipe_reg #(.payload_t(id_ex_t)) id_ex_reg_i (
        .clk_50MHz(clk_50MHz), .rst(rst), .hold_i(1'b0), .clear_i(bubble | flush),
        .data_i(id_ex_d), .data_o(id_ex_q)
    );

    // ****************************************
    // EX
    // ****************************************
    execute_unit execute_unit_i (
        .id_ex_i(id_ex_q),
        .mem_dest_i(ex_mem_q.dest), .mem_reg_write_i(ex_mem_q.reg_write),
        .mem_is_load_i(ex_mem_q.mem_read), .mem_result_i(ex_mem_q.result),
        .wb_dest_i(mem_wb_q.dest), .wb_reg_write_i(mem_wb_q.reg_write), .wb_data_i(wb_data),
        .result_o(ex_result), .store_data_o(ex_store_data),
        .take_branch_o(take_branch), .branch_target_o(branch_target)
    );

    assign ex_mem_d = '{result: ex_result, store_data: ex_store_data, dest: id_ex_q.dest,
                        reg_write: id_ex_q.reg_write, wb_src: id_ex_q.wb_src,
                        mem_read: id_ex_q.mem_read, mem_write: id_ex_q.mem_write};

    pipe_reg #(.payload_t(ex_mem_t)) ex_mem_reg_i (
        .clk_50MHz(clk_50MHz), .rst(rst), .hold_i(1'b0), .clear_i(1'b0),
        .data_i(ex_mem_d), .data_o(ex_mem_q)
    );

    // MEM with the data memory outside
    assign dmem_en_o    = ex_mem_q.mem_read | ex_mem_q.mem_write;
    assign dmem_we_o    = ex_mem_q.mem_write;
    assign dmem_addr_o  = ex_mem_q.result;
    assign dmem_wdata_o = ex_mem_q.store_data;

    assign mem_wb_d = '{result: ex_mem_q.result, load_data: dmem_rdata_i,
                        dest: ex_mem_q.dest, reg_write: ex_mem_q.reg_write,
                        wb_src: ex_mem_q.wb_src};

    pipe_reg #(.payload_t(mem_wb_t)) mem_wb_reg_i (
        .clk_50MHz(clk_50MHz), .rst(rst), .hold_i(1'b0), .clear_i(1'b0),
        .data_i(mem_wb_d), .data_o(mem_wb_q)
    );

endmodule

/* cpu_chk.sv */
`timescale 1ns/100ps

module cpu_chk (
    input logic clk_50MHz,
    input logic rst,
    input logic dmem_en_i,
    input logic dmem_we_i,
    input logic stall_i
);

    int fails = 0;

    // a write is always an access
    assert property (@(posedge clk_50MHz) dmem_we_i |-> dmem_en_i)
        else begin
            fails++;
            $error("data write strobe without enable");
        end

    assert property (@(posedge clk_50MHz) !rst |-> !dmem_en_i && !dmem_we_i)
        else begin
            fails++;
            $error("data strobe active in reset");
        end

    // one bubble per load-use
    assert property (@(posedge clk_50MHz) disable iff (!rst) stall_i |=> !stall_i)
        else begin
            fails++;
            $error("stall held for two cycles");
        end

endmodule

bind cpu_top cpu_chk cpu_chk_i (
    .clk_50MHz(clk_50MHz),
    .rst(rst),
    .dmem_en_i(dmem_en_o),
    .dmem_we_i(dmem_we_o),
    .stall_i(stall)
);

/* cpu_tb.sv */
`timescale 1ns/100ps

module cpu_tb import cpu_pkg::*; ();

    localparam int NUM_PROGS = 23;
    localparam int RAND_LEN  = 40;

    logic  clk_50MHz;
    logic  rst;
    inst_t imem_data_i;
    pc_t   imem_addr_o;
    word_t dmem_rdata_i;
    logic  dmem_en_o;
    logic  dmem_we_o;
    word_t dmem_addr_o;
    word_t dmem_wdata_o;

    inst_t       imem [256];
    word_t       dmem [256];
    word_t       dmem_init [256];
    inst_t       progs [NUM_PROGS][256];
    int          prog_len [NUM_PROGS];
    string       prog_name [NUM_PROGS];
    word_t       exp_addr [$];
    word_t       exp_data [$];
    string       test_name;
    logic [31:0] lcg_state = 32'h23e9;
    int          errors = 0;
    int          budget = 0;
    int          cur;

    cpu_top cpu_top_i (.*);

    initial begin
        clk_50MHz = 1'b0;
        forever #10 clk_50MHz = ~clk_50MHz;
    end

    // ****************************************
    // memory models
    // ****************************************
    assign imem_data_i  = imem[imem_addr_o[7:0]];
    // read data only while the port is enabled
    assign dmem_rdata_i = dmem_en_o ? dmem[dmem_addr_o[7:0]] : 'x;

    always @(posedge clk_50MHz) begin
        if (dmem_we_o)
            dmem[dmem_addr_o[7:0]] <= dmem_wdata_o;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic emit(input inst_t inst);
        progs[cur][prog_len[cur]] = inst;
        prog_len[cur]++;
    endtask

    task automatic check_value(input string what, input word_t exp, input word_t act);
        if (exp !== act) begin
            errors++;
            $display("error %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    // ISA level model that fills the expected store queues
    function automatic void ref_run(input int p);
        word_t regs [NUM_REGS];
        word_t mem [256];
        pc_t   pc;
        inst_t ins;
        word_t rx_val;
        word_t ry_val;
        word_t addr;
        pc = '0;
        mem = dmem_init;
        exp_addr.delete();
        exp_data.delete();
        foreach (regs[i])
            regs[i] = '0;
        for (int step = 0; step < 1000; step++) begin
            ins = progs[p][pc[7:0]];
            if (ins == {OP_B, 11'h7ff})
                break;
            pc = pc + 1;
            rx_val = regs[ins[10:8]];
            ry_val = regs[ins[7:5]];
            addr = rx_val + {{11{ins[4]}}, ins[4:0]};
            case (ins[15:11])
                OP_LI:    regs[ins[10:8]] = {8'b0, ins[7:0]};
                OP_ADDIU: regs[ins[10:8]] = rx_val + {{8{ins[7]}}, ins[7:0]};
                OP_RRR: begin
                    if (ins[1:0] == FUNCT_ADDU)
                        regs[ins[4:2]] = rx_val + ry_val;
                    else if (ins[1:0] == FUNCT_SUBU)
                        regs[ins[4:2]] = rx_val - ry_val;
                end
                OP_LW:    regs[ins[7:5]] = mem[addr[7:0]];
                OP_SW: begin
                    mem[addr[7:0]] = ry_val;
                    exp_addr.push_back(addr);
                    exp_data.push_back(ry_val);
                end
                OP_BEQZ: begin
                    if (rx_val == '0)
                        pc = pc + {{8{ins[7]}}, ins[7:0]};
                end
                OP_B:     pc = pc + {{5{ins[10]}}, ins[10:0]};
                default:  ;
            endcase
        end
    endfunction

    // store monitor
    always @(posedge clk_50MHz) begin
        if (rst && dmem_we_o) begin
            if (exp_addr.size() == 0) begin
                errors++;
                $display("%s: the CPU made a store the reference model does not make", test_name);
            end else begin
                check_value("store address", exp_addr.pop_front(), dmem_addr_o);
                check_value("store data", exp_data.pop_front(), dmem_wdata_o);
            end
        end
    end

    // ****************************************
    // programs
    // ****************************************
    task automatic build_directed();
        cur = 0;
        prog_name[0] = "dependent_chains";
        emit({OP_LI, 3'd1, 8'h34});
        emit({OP_ADDIU, 3'd1, 8'hf0});
        emit({OP_LI, 3'd2, 8'h07});
        emit({OP_RRR, 3'd1, 3'd2, 3'd3, FUNCT_ADDU});
        emit({OP_RRR, 3'd3, 3'd1, 3'd4, FUNCT_SUBU});
        emit({OP_SW, 3'd0, 3'd4, 5'd1});
        emit({OP_RRR, 3'd2, 3'd3, 3'd5, FUNCT_SUBU});
        emit({OP_SW, 3'd4, 3'd5, 5'd3});
        emit({OP_ADDIU, 3'd5, 8'h80});
        emit({OP_SW, 3'd5, 3'd3, 5'h1f});
        emit({OP_B, 11'h7ff});
        cur = 1;
        prog_name[1] = "load_use";
        emit({OP_LI, 3'd1, 8'h20});
        emit({OP_SW, 3'd1, 3'd1, 5'd0});
        emit({OP_LW, 3'd1, 3'd2, 5'd0});
        emit({OP_ADDIU, 3'd2, 8'h01});
        emit({OP_SW, 3'd1, 3'd2, 5'd1});
        emit({OP_LW, 3'd1, 3'd3, 5'd5});
        emit({OP_SW, 3'd1, 3'd3, 5'd2});
        emit({OP_LW, 3'd0, 3'd4, 5'd3});
        emit({OP_RRR, 3'd4, 3'd4, 3'd5, FUNCT_ADDU});
        emit({OP_SW, 3'd0, 3'd5, 5'd4});
        emit({OP_B, 11'h7ff});
        cur = 2;
        prog_name[2] = "branches";
        emit({OP_LI, 3'd1, 8'h00});
        emit({OP_BEQZ, 3'd1, 8'd2});
        emit({OP_SW, 3'd0, 3'd1, 5'd8});
        emit({OP_SW, 3'd0, 3'd1, 5'd9});
        emit({OP_LI, 3'd2, 8'h05});
        emit({OP_BEQZ, 3'd2, 8'd1});
        emit({OP_SW, 3'd0, 3'd2, 5'd10});
        emit({OP_SW, 3'd0, 3'd1, 5'd12});
        emit({OP_LW, 3'd0, 3'd3, 5'd12});
        emit({OP_BEQZ, 3'd3, 8'd2});
        emit({OP_SW, 3'd0, 3'd3, 5'd14});
        emit({OP_SW, 3'd0, 3'd3, 5'd15});
        emit({OP_LW, 3'd0, 3'd4, 5'd10});
        emit({OP_BEQZ, 3'd4, 8'd1});
        emit({OP_B, 11'd2});
        emit({OP_SW, 3'd0, 3'd2, 5'd16});
        emit({OP_SW, 3'd0, 3'd2, 5'd17});
        emit({OP_SW, 3'd0, 3'd4, 5'd18});
        emit({OP_B, 11'h7ff});
    endtask

    task automatic build_random(input int p);
        logic [31:0] r;
        logic [31:0] f;
        int          off;
        cur = p;
        prog_name[p] = $sformatf("random_%0d", p - 3);
        for (int i = 0; i < RAND_LEN - 1; i++) begin
            r = lcg_next();
            f = lcg_next();
            // forward only and never past the closing self-loop
            off = f[17:16];
            if (i + 1 + off > RAND_LEN - 1)
                off = 0;
            case (r[31:28])
                4'd0, 4'd1:  emit({OP_LI, r[27:25], f[31:24]});
                4'd2, 4'd3:  emit({OP_ADDIU, r[27:25], f[31:24]});
                4'd4, 4'd5:  emit({OP_RRR, r[27:25], r[24:22], r[21:19], FUNCT_ADDU});
                4'd6:        emit({OP_RRR, r[27:25], r[24:22], r[21:19], FUNCT_SUBU});
                4'd7, 4'd8:  emit({OP_LW, r[27:25], r[24:22], f[28:24]});
                4'd9, 4'd10: emit({OP_SW, r[27:25], r[24:22], f[28:24]});
                4'd11:       emit({OP_BEQZ, r[27:25], 8'(off)});
                4'd12:       emit({OP_B, 11'(off)});
                default:     emit({OP_NOP, 11'b0});
            endcase
        end
        emit({OP_B, 11'h7ff});
    endtask

    task automatic run_program(input int p);
        logic [31:0] r;
        test_name = prog_name[p];
        rst <= 1'b0;
        @(posedge clk_50MHz);
        for (int a = 0; a < 256; a++) begin
            r = lcg_next();
            imem[a] = progs[p][a];
            dmem[a] = r[31:16];
            dmem_init[a] = r[31:16];
        end
        ref_run(p);
        repeat (3) begin
            check_value("strobes in reset", '0, word_t'({dmem_en_o, dmem_we_o}));
            @(posedge clk_50MHz);
        end
        rst <= 1'b1;
        @(posedge clk_50MHz);
        check_value("first fetch address", '0, imem_addr_o);
        check_value("strobes after reset", '0, word_t'({dmem_en_o, dmem_we_o}));
        repeat (prog_len[p] * 4 + 20) @(posedge clk_50MHz);
        if (exp_addr.size() != 0) begin
            errors++;
            $display("%s: %0d expected stores never showed up", test_name, exp_addr.size());
        end
    endtask

    initial begin
        wait (budget > 0);
        repeat (budget) @(posedge clk_50MHz);
        $display("timeout: the run took longer than %0d cycles", budget);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        rst = 1'b1;
        for (int p = 0; p < NUM_PROGS; p++) begin
            prog_len[p] = 0;
            for (int a = 0; a < 256; a++)
                progs[p][a] = {OP_NOP, 3'b0, a[7:0]};
        end
        build_directed();
        for (int p = 3; p < NUM_PROGS; p++)
            build_random(p);
        for (int p = 0; p < NUM_PROGS; p++)
            budget += prog_len[p] * 8 + 50;
        @(posedge clk_50MHz);
        for (int p = 0; p < NUM_PROGS; p++)
            run_program(p);
        errors += cpu_top_i.cpu_chk_i.fails;
        $display("run complete, %0d errors", errors);
        if (errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

/* sim.f */
cpu_pkg.sv
fetch_unit.sv
pipe_reg.sv
decoder.sv
reg_file.sv
hazard_unit.sv
execute_unit.sv
cpu_top.sv
cpu_chk.sv
cpu_tb.sv
